//--- flist.f
rtl/fsqrt_pkg.sv
rtl/fsqrt_dispatch.sv
rtl/fsqrt_mant_iter.sv
rtl/fsqrt_unit.sv
rtl/fsqrt_collect.sv
rtl/fsqrt_array.sv
sim/fsqrt_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fsqrt testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f flist.f --top-module fsqrt_tb -o fsqrt_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/fsqrt_sim > sim.log 2>&1
status=$?
cat sim.log

# the log decides pass or fail
if grep -q "Checks failed" sim.log; then
   echo "FAIL"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
echo "PASS"
exit 0

//--- sim/fsqrt_tb.sv
`timescale 1ns/10ps

module fsqrt_tb;
   import fsqrt_pkg::*;

   localparam int          TIMEOUT = 200;            // cycles per wait
   localparam logic [31:0] SEED    = 32'h90591dc6;

   logic            CLK;
   logic            arst_n;
   logic [FP_W-1:0] in_data;
   logic            in_valid;
   logic            in_ready;
   logic [FP_W-1:0] out_data;
   logic            out_valid;
   logic            out_ready;
   logic [FP_W-1:0] exp_q[$];      // expected roots, input order
   string           cur_test;
   logic            saw_stall;     // in_valid seen waiting on in_ready
   int              max_pending;

   fsqrt_array fsqrt_array_i (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .in_data   (in_data),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_data  (out_data),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial
   begin
      CLK = 1'b0;
      forever #5 CLK = ~CLK;    // 10 ns
   end

   task automatic check_word(input string what, input logic [FP_W-1:0] expv,
                             input logic [FP_W-1:0] actv);
      if (actv !== expv)
      begin
         $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, expv, actv);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   task automatic check_flag(input string what, input logic expv, input logic actv);
      if (actv !== expv)
      begin
         $display("[ERROR] %s %s: expected %b, actual %b", cur_test, what, expv, actv);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   task automatic abort_timeout(input string what);
      $display("%s: timeout waiting for %s", cur_test, what);
      $display("Checks failed");
      $fatal(1);
   endtask

   // truncated root by bitwise search
   function automatic logic [FP_W-1:0] model_sqrt(input logic [FP_W-1:0] x);
      int                e;
      int                u;
      int                half;
      longint unsigned   rad;
      longint unsigned   r;
      longint unsigned   bitv;
      e = int'(x[FP_W-2 -: EXP_W]);
      u = e - EXP_BIAS;
      half = u / 2;
      if (u < 0 && (u % 2) != 0)
      begin
         half = half - 1;    // floor for negative odd
      end
      rad = 64'({1'b1, x[MAN_W-1:0]}) << (((u % 2) == 0) ? 23 : 24);
      r = 0;
      for (int b = SIG_W; b >= 0; b--)
      begin
         bitv = 64'd1 << b;
         if ((r + bitv) * (r + bitv) <= rad)
            r = r + bitv;
      end
      if (e == 0)
         return {x[FP_W-1], {(FP_W-1){1'b0}}};    // signed zero
      else
         return {x[FP_W-1], EXP_W'(half + EXP_BIAS), r[MAN_W-1:0]};
   endfunction

   // any sign, exponent clear of 0 and 255
   function automatic logic [FP_W-1:0] random_normal();
      logic [31:0] r;
      r = $urandom;
      return {r[31], EXP_W'($urandom_range(254, 1)), r[MAN_W-1:0]};
   endfunction

   // called at posedge + 1, returns at posedge + 1 after the accepting edge
   task automatic send_operand(input logic [FP_W-1:0] word);
      int cnt;
      in_data  = word;
      in_valid = 1'b1;
      cnt      = 0;
      @(negedge CLK);
      while (!in_ready && cnt < TIMEOUT)
      begin
         @(negedge CLK);
         cnt++;
      end
      if (!in_ready)
         abort_timeout("in_ready");
      exp_q.push_back(model_sqrt(word));    // accepted on the coming edge
      if (exp_q.size() > max_pending)
         max_pending = exp_q.size();
      @(posedge CLK);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic send_all(input logic [FP_W-1:0] ops[$]);
      foreach (ops[i])
         send_operand(ops[i]);    // back to back
   endtask

   // out_ready low for hold cycles, then high or random
   // returns at posedge + 1 with out_ready low again
   task automatic receive_results(input int n, input logic rand_ready, input int hold);
      logic [FP_W-1:0] prev_data;
      logic            prev_wait;
      logic [31:0]     r;
      int              got;
      int              k;
      int              idle;
      prev_data = '0;
      prev_wait = 1'b0;
      got       = 0;
      k         = 0;
      idle      = 0;
      while (got < n)
      begin
         @(posedge CLK);
         #1;
         r = $urandom;
         if (k < hold)
            out_ready = 1'b0;
         else if (rand_ready)
            out_ready = r[0];
         else
            out_ready = 1'b1;
         k++;
         @(negedge CLK);
         if (prev_wait)    // stalled last cycle, word must not move
         begin
            check_flag("out_valid held", 1'b1, out_valid);
            check_word("out_data held", prev_data, out_data);
         end
         if (in_valid && !in_ready)
            saw_stall = 1'b1;
         if (out_valid && out_ready)
         begin
            if (exp_q.size() == 0)
            begin
               $display("%s: result came out with no operand sent", cur_test);
               $display("Checks failed");
               $fatal(1);
            end
            else
            begin
               check_word("result", exp_q.pop_front(), out_data);
               got++;
               idle = 0;
            end
         end
         else
         begin
            idle++;
            if (idle > hold + TIMEOUT)
               abort_timeout("out_valid");
         end
         prev_wait = out_valid && !out_ready;
         prev_data = out_data;
      end
      @(posedge CLK);    // last handshake completes here
      #1;
      out_ready = 1'b0;    // stray results wait in the output register
   endtask

   task automatic test_reset();
      cur_test = "test_reset";
      @(negedge CLK);
      check_flag("in_ready", 1'b1, in_ready);
      check_flag("out_valid", 1'b0, out_valid);
      @(posedge CLK);
      #1;
   endtask

   task automatic run_known(input logic [FP_W-1:0] ins[$], input logic [FP_W-1:0] outs[$]);
      foreach (ins[i])
      begin
         check_word("model", outs[i], model_sqrt(ins[i]));    // model vs hand value
         send_operand(ins[i]);
         receive_results(1, 1'b0, 0);    // one at a time
      end
   endtask

   task automatic test_exact_squares();
      cur_test = "test_exact_squares";
      // 1, 4, 9, 0.25, 2
      run_known('{32'h3F800000, 32'h40800000, 32'h41100000, 32'h3E800000, 32'h40000000},
                '{32'h3F800000, 32'h40000000, 32'h40400000, 32'h3F000000, 32'h3FB504F3});
   endtask

   task automatic test_zero_and_sign();
      cur_test = "test_zero_and_sign";
      // +0, -0, subnormal, -4
      run_known('{32'h00000000, 32'h80000000, 32'h00012345, 32'hC0800000},
                '{32'h00000000, 32'h80000000, 32'h00000000, 32'hC0000000});
   endtask

   task automatic test_stream_order();
      logic [FP_W-1:0] ops[$];
      cur_test    = "test_stream_order";
      max_pending = 0;
      repeat (12)
         ops.push_back(random_normal());    // drawn before the fork
      fork
         send_all(ops);
         receive_results(12, 1'b0, 0);
      join
      check_flag("several in flight", 1'b1, max_pending >= N_UNITS);
   endtask

   task automatic test_backpressure();
      logic [FP_W-1:0] ops[$];
      cur_test  = "test_backpressure";
      saw_stall = 1'b0;
      repeat (8)
         ops.push_back(random_normal());
      fork
         send_all(ops);
         receive_results(8, 1'b1, 60);    // stall long enough to fill all units
      join
      check_flag("in_ready fell", 1'b1, saw_stall);
   endtask

   initial
   begin
      void'($urandom(SEED));    // single seed for the run
      in_data     = '0;
      in_valid    = 1'b0;
      out_ready   = 1'b0;
      arst_n      = 1'b0;
      saw_stall   = 1'b0;
      max_pending = 0;
      cur_test    = "reset";
      repeat (2) @(posedge CLK);
      #1;
      arst_n = 1'b1;
      test_reset();
      test_exact_squares();
      test_zero_and_sign();
      test_stream_order();
      test_backpressure();
      if (exp_q.size() == 0)
      begin
         $display("All checks passed");
         $finish;
      end
      else
      begin
         $display("%0d results never came out", exp_q.size());
         $display("Checks failed");
         $fatal(1);
      end
   end

endmodule

//--- rtl/fsqrt_array.sv
`timescale 1ns/10ps

module fsqrt_array (
   input  logic                         CLK,
   input  logic                         arst_n,
   input  logic [fsqrt_pkg::FP_W-1:0]   in_data,
   input  logic                         in_valid,
   output logic                         in_ready,
   output logic [fsqrt_pkg::FP_W-1:0]   out_data,
   output logic                         out_valid,
   input  logic                         out_ready
);
   import fsqrt_pkg::*;

   logic [FP_W-1:0]                 op_data;          // shared operand bus
   logic [N_UNITS-1:0]              unit_start;
   logic [N_UNITS-1:0]              unit_busy;
   logic [N_UNITS-1:0][FP_W-1:0]    unit_res;
   logic [N_UNITS-1:0]              unit_res_valid;
   logic [N_UNITS-1:0]              unit_take;

   fsqrt_dispatch fsqrt_dispatch_i (
      .CLK        (CLK),
      .arst_n     (arst_n),
      .in_data    (in_data),
      .in_valid   (in_valid),
      .unit_busy  (unit_busy),
      .in_ready   (in_ready),
      .op_data    (op_data),
      .unit_start (unit_start)
   );

   // identical iterative cores
   for (genvar i = 0; i < N_UNITS; i++)
   begin : g_unit
      fsqrt_unit fsqrt_unit_i (
         .CLK       (CLK),
         .arst_n    (arst_n),
         .start     (unit_start[i]),
         .op_data   (op_data),
         .take      (unit_take[i]),
         .busy      (unit_busy[i]),
         .res       (unit_res[i]),
         .res_valid (unit_res_valid[i])
      );
   end

   fsqrt_collect fsqrt_collect_i (
      .CLK            (CLK),
      .arst_n         (arst_n),
      .unit_res       (unit_res),
      .unit_res_valid (unit_res_valid),
      .out_ready      (out_ready),
      .unit_take      (unit_take),
      .out_data       (out_data),
      .out_valid      (out_valid)
   );

endmodule

//--- rtl/fsqrt_collect.sv
`timescale 1ns/10ps

module fsqrt_collect (
   input  logic                                             CLK,
   input  logic                                             arst_n,
   input  logic [fsqrt_pkg::N_UNITS-1:0][fsqrt_pkg::FP_W-1:0] unit_res,
   input  logic [fsqrt_pkg::N_UNITS-1:0]                    unit_res_valid,
   input  logic                                             out_ready,
   output logic [fsqrt_pkg::N_UNITS-1:0]                    unit_take,
   output logic [fsqrt_pkg::FP_W-1:0]                       out_data,
   output logic                                             out_valid
);
   import fsqrt_pkg::*;

   logic [UNIT_IDX_W-1:0] ptr;         // unit whose result is due next
   logic                  room;        // output register free by the next edge
   logic                  load;

   // empty, or emptied by a handshake this cycle
   assign room = ~out_valid | out_ready;
   assign load = room & unit_res_valid[ptr];

   // take strobe back to the pointed unit
   always_comb
   begin
      unit_take = '0;
      if (load)
      begin
         unit_take[ptr] = 1'b1;
      end
   end

   // pointer and valid
   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ptr       <= '0;
         out_valid <= 1'b0;
      end
      else
      begin
         if (load)
         begin
            out_valid <= 1'b1;
            if (ptr == UNIT_IDX_W'(N_UNITS - 1))
            begin
               ptr <= '0;
            end
            else
            begin
               ptr <= ptr + 1'b1;    // same rotation as the dispatcher
            end
         end
         else if (out_valid && out_ready)
         begin
            out_valid <= 1'b0;    // drained, nothing new behind it
         end
      end
   end

   // output word only changes on a load, so it is stable while out_valid waits
   always_ff @(posedge CLK)
   begin
      if (load)
      begin
         out_data <= unit_res[ptr];
      end
   end

endmodule

//--- rtl/fsqrt_unit.sv
`timescale 1ns/10ps

module fsqrt_unit (
   input  logic                         CLK,
   input  logic                         arst_n,
   input  logic                         start,
   input  logic [fsqrt_pkg::FP_W-1:0]   op_data,
   input  logic                         take,
   output logic                         busy,
   output logic [fsqrt_pkg::FP_W-1:0]   res,
   output logic                         res_valid
);
   import fsqrt_pkg::*;

   logic [FP_W-1:0]         op_reg;      // operand, stable until the next start
   logic                    go_r;        // start delayed one edge
   logic                    iter_go;
   logic                    sgn;
   logic [EXP_W-1:0]        exp_in;
   logic                    exp_nz;      // hidden bit, low for zero or subnormal
   logic signed [EXP_W+1:0] exp_unb;     // unbiased exponent
   logic signed [EXP_W+1:0] exp_half;    // floor of half
   logic [EXP_W-1:0]        exp_res;
   logic                    exp_odd;
   logic [SIG_W-1:0]        sig;
   logic [RAD_W-1:0]        radicand;
   logic [SIG_W-1:0]        root;
   logic                    iter_done;
   iter_state_t             iter_state;
   logic [FP_W-1:0]         res_nxt;

   // field split
   assign sgn    = op_reg[FP_W-1];          // passes straight through
   assign exp_in = op_reg[FP_W-2 -: EXP_W];
   assign exp_nz = |exp_in;
   assign sig    = {exp_nz, op_reg[MAN_W-1:0]};

   // exponent path, unbias, halve, rebias
   assign exp_unb  = signed'({2'b00, exp_in}) - (EXP_W+2)'(EXP_BIAS);
   assign exp_half = exp_unb >>> 1;    // arithmetic, rounds toward -inf
   assign exp_res  = EXP_W'(exp_half + (EXP_W+2)'(EXP_BIAS));
   assign exp_odd  = exp_unb[0];

   // odd exponent gets the extra left shift
   // so the radicand always carries an even power of two
   always_comb
   begin
      if (exp_odd)
      begin
         radicand = {sig, {(RAD_W-SIG_W){1'b0}}};
      end
      else
      begin
         radicand = {1'b0, sig, {(RAD_W-SIG_W-1){1'b0}}};
      end
   end

   // only kick the core when it sits idle
   assign iter_go = go_r && (iter_state == ST_IDLE);

   fsqrt_mant_iter fsqrt_mant_iter_i (
      .CLK      (CLK),
      .arst_n   (arst_n),
      .go       (iter_go),
      .radicand (radicand),
      .root     (root),
      .done     (iter_done),
      .state    (iter_state)
   );

   // truncated root, zero exponent flushes to signed zero
   assign res_nxt = {sgn, exp_res & {EXP_W{exp_nz}}, root[MAN_W-1:0] & {MAN_W{exp_nz}}};

   // handshake state
   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         go_r      <= 1'b0;
         busy      <= 1'b0;
         res_valid <= 1'b0;
      end
      else
      begin
         go_r <= start;
         if (take)
         begin
            busy <= 1'b0;    // free again once collected
         end
         else if (start)
         begin
            busy <= 1'b1;
         end
         if (take)
         begin
            res_valid <= 1'b0;
         end
         else if (iter_done)
         begin
            res_valid <= 1'b1;    // held until the collector takes it
         end
      end
   end

   // operand and result words
   always_ff @(posedge CLK)
   begin
      if (start)
      begin
         op_reg <= op_data;
      end
      if (iter_done)
      begin
         res <= res_nxt;
      end
   end

endmodule

//--- rtl/fsqrt_mant_iter.sv
`timescale 1ns/10ps

module fsqrt_mant_iter (
   input  logic                            CLK,
   input  logic                            arst_n,
   input  logic                            go,
   input  logic [fsqrt_pkg::RAD_W-1:0]     radicand,
   output logic [fsqrt_pkg::SIG_W-1:0]     root,
   output logic                            done,
   output fsqrt_pkg::iter_state_t          state
);
   import fsqrt_pkg::*;

   logic [$clog2(ITER_CNT)-1:0] step_cnt;   // steps taken so far
   logic [RAD_W-1:0]            rad_sh;     // radicand, top pair brought down each step
   logic [SIG_W+1:0]            rem;        // partial remainder, at most 2*root
   logic [SIG_W+3:0]            rem_sh;     // remainder with next pair appended
   logic [SIG_W+3:0]            trial;      // root followed by 01
   logic [SIG_W+3:0]            diff;
   logic                        fits;       // trial subtraction stays nonnegative
   logic                        load;

   assign load = go && (state == ST_IDLE);

   // one restoring step
   assign rem_sh = {rem, rad_sh[RAD_W-1 -: 2]};
   assign trial  = {2'b00, root, 2'b01};
   assign diff   = rem_sh - trial;
   assign fits   = ~diff[SIG_W+3];    // sign of the difference

   assign done = (state == ST_DONE);    // single cycle, state leaves DONE next edge

   // controller
   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= ST_IDLE;
         step_cnt <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (go)
               begin
                  state    <= ST_ITER;
                  step_cnt <= '0;
               end
            end
            ST_ITER:
            begin
               step_cnt <= step_cnt + 1'b1;
               if (step_cnt == ($clog2(ITER_CNT))'(ITER_CNT - 1))
               begin
                  state <= ST_DONE;    // last root bit lands this edge
               end
            end
            default:
            begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // datapath
   always_ff @(posedge CLK)
   begin
      if (load)
      begin
         rad_sh <= radicand;
         rem    <= '0;
         root   <= '0;
      end
      else if (state == ST_ITER)
      begin
         rad_sh <= {rad_sh[RAD_W-3:0], 2'b00};
         rem    <= fits ? diff[SIG_W+1:0] : rem_sh[SIG_W+1:0];    // restore on miss
         root   <= {root[SIG_W-2:0], fits};
      end
   end

endmodule

//--- rtl/fsqrt_dispatch.sv
`timescale 1ns/10ps

module fsqrt_dispatch (
   input  logic                              CLK,
   input  logic                              arst_n,
   input  logic [fsqrt_pkg::FP_W-1:0]        in_data,
   input  logic                              in_valid,
   input  logic [fsqrt_pkg::N_UNITS-1:0]     unit_busy,
   output logic                              in_ready,
   output logic [fsqrt_pkg::FP_W-1:0]        op_data,
   output logic [fsqrt_pkg::N_UNITS-1:0]     unit_start
);
   import fsqrt_pkg::*;

   logic [UNIT_IDX_W-1:0] ptr;       // next unit in the rotation
   logic                  accept;    // input handshake this cycle

   // strict rotation, never skip a busy unit
   // otherwise results would need tags to come back in order
   assign in_ready = ~unit_busy[ptr];
   assign accept   = in_valid & in_ready;

   // shared operand bus, only the started unit samples it
   assign op_data = in_data;

   // one-hot start strobe for the pointed unit
   always_comb
   begin
      unit_start = '0;
      if (accept)
      begin
         unit_start[ptr] = 1'b1;
      end
   end

   // pointer moves on every accepted operand
   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ptr <= '0;
      end
      else if (accept)
      begin
         if (ptr == UNIT_IDX_W'(N_UNITS - 1))
         begin
            ptr <= '0;    // wrap
         end
         else
         begin
            ptr <= ptr + 1'b1;
         end
      end
   end

endmodule

//--- rtl/fsqrt_pkg.sv
package fsqrt_pkg;

   // single precision word layout
   localparam int FP_W  = 32;            // whole word
   localparam int EXP_W = 8;             // biased exponent field
   localparam int MAN_W = 23;            // stored fraction, no hidden bit
   localparam int SIG_W = MAN_W + 1;     // fraction plus hidden bit

   // radicand is twice the root width, so the root comes out SIG_W wide
   localparam int RAD_W = 2 * SIG_W;

   localparam int EXP_BIAS = 127;        // ieee 754 single bias

   // array of iterative cores
   localparam int N_UNITS    = 4;
   localparam int UNIT_IDX_W = $clog2(N_UNITS);   // round-robin pointer

   // one root bit per step
   localparam int ITER_CNT = SIG_W;

   // iteration controller
   typedef enum logic [1:0]
   {
      ST_IDLE,    // waiting for go
      ST_ITER,    // shifting out root bits
      ST_DONE     // root ready, single cycle
   } iter_state_t;

endpackage
